/* design/layer_shape_pkg.sv */
package layer_shape_pkg;

    // Layer dimensions
    localparam int IMG_WIDTH    = 8;
    localparam int KERNEL_SIZE  = 3;
    localparam int IN_CHANNELS  = 2;
    localparam int OUT_CHANNELS = 2;
    localparam int OUT_WIDTH    = IMG_WIDTH - KERNEL_SIZE + 1;

    // Fixed-point settings, all values unsigned
    localparam int VALUE_BITS       = 8;
    localparam int WEIGHT_BITS      = 8;
    localparam int WEIGHT_Q_SHIFT   = 4;
    localparam int PRODUCT_BITS     = VALUE_BITS + WEIGHT_BITS;
    localparam int TAG_BITS         = 4;
    localparam int WEIGHT_COUNT     = OUT_CHANNELS * IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE;
    localparam int WEIGHT_ADDR_BITS = 6;

    typedef logic [VALUE_BITS-1:0]       pixel_t;
    typedef logic [WEIGHT_BITS-1:0]      weight_t;
    typedef logic [PRODUCT_BITS-1:0]     product_t;
    typedef logic [WEIGHT_ADDR_BITS-1:0] weight_addr_t;
    typedef logic [TAG_BITS-1:0]         tag_t;

    // Rows are indexed [column][channel]
    typedef pixel_t [IMG_WIDTH-1:0][IN_CHANNELS-1:0]  in_row_t;
    typedef pixel_t [OUT_WIDTH-1:0][OUT_CHANNELS-1:0] out_row_t;

    // Windows are indexed [in channel][dx][dy], dy 0 being the oldest row
    typedef pixel_t  [IN_CHANNELS-1:0][KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] window_t;
    typedef weight_t [IN_CHANNELS-1:0][KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] weight_set_t;

    // Flat weight address, dy varies fastest
    function automatic int weight_index(int out_ch, int in_ch, int dx, int dy);
        return ((out_ch * IN_CHANNELS + in_ch) * KERNEL_SIZE + dx) * KERNEL_SIZE + dy;
    endfunction

endpackage

/* design/layer_ctrl_pkg.sv */
package layer_ctrl_pkg;

    import layer_shape_pkg::*;

    // Counter widths
    localparam int COL_IDX_BITS = $clog2(IMG_WIDTH + 1);
    localparam int CH_IDX_BITS  = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1;
    localparam int FILL_BITS    = $clog2(KERNEL_SIZE + 1);

    typedef enum logic [1:0] {
        GET_ROW,
        COMPUTE,
        WAIT_READ
    } ctrl_state_t;

    typedef logic [COL_IDX_BITS-1:0] col_idx_t;
    typedef logic [CH_IDX_BITS-1:0]  ch_idx_t;
    typedef logic [FILL_BITS-1:0]    row_fill_t;

endpackage

/* design/window_if.sv */
`timescale 1ns/1ns

interface window_if
    import layer_shape_pkg::*;
();

    // Row shift pushes next_row in as the newest row
    logic    shift_row;
    // Column shift rotates every row left by one pixel
    logic    shift_col;
    in_row_t next_row;
    window_t taps;

    modport buffer (
        input  shift_row,
        input  shift_col,
        input  next_row,
        output taps
    );

    modport ctrl (
        output shift_row,
        output shift_col,
        output next_row
    );

    modport mac (
        input taps
    );

endinterface

/* design/row_window_buffer.sv */
`timescale 1ns/1ns

module row_window_buffer
    import layer_shape_pkg::*;
(
    input  logic     clock_i,
    input  logic     reset_i,
    window_if.buffer win
);

    // Row 0 is the oldest, row KERNEL_SIZE-1 the newest
    in_row_t rows_q [KERNEL_SIZE];

    always_ff @(posedge clock_i) begin
        if (win.shift_row) begin
            for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                rows_q[r] <= rows_q[r + 1];
            end
            rows_q[KERNEL_SIZE-1] <= win.next_row;
        end else if (win.shift_col) begin
            // Column 0 wraps around to the end of each row
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < IMG_WIDTH - 1; c++) begin
                    rows_q[r][c] <= rows_q[r][c + 1];
                end
                rows_q[r][IMG_WIDTH-1] <= rows_q[r][0];
            end
        end
    end

    // Window is always the first KERNEL_SIZE columns
    always_comb begin
        for (int ch = 0; ch < IN_CHANNELS; ch++) begin
            for (int dx = 0; dx < KERNEL_SIZE; dx++) begin
                for (int dy = 0; dy < KERNEL_SIZE; dy++) begin
                    win.taps[ch][dx][dy] = rows_q[dy][dx][ch];
                end
            end
        end
    end

    // Controller must never ask for both shifts in one cycle
    shift_exclusive_a: assert property (
        @(posedge clock_i) disable iff (reset_i)
        !(win.shift_row && win.shift_col)
    ) else $error("row and column shift requested together");

endmodule

/* design/weight_bank.sv */
`timescale 1ns/1ns

module weight_bank
    import layer_shape_pkg::*;
    import layer_ctrl_pkg::*;
(
    input  logic         clock_i,
    input  logic         reset_i,
    input  logic         weight_we_i,
    input  weight_addr_t weight_addr_i,
    input  weight_t      weight_data_i,
    input  ch_idx_t      out_ch_i,
    output weight_set_t  weights_o
);

    weight_t weights_q [WEIGHT_COUNT];

    // Single-cycle write strobe, always accepted
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int a = 0; a < WEIGHT_COUNT; a++) begin
                weights_q[a] <= '0;
            end
        end else if (weight_we_i && (int'(weight_addr_i) < WEIGHT_COUNT)) begin
            weights_q[weight_addr_i] <= weight_data_i;
        end
    end

    // Read the set for the current output channel
    always_comb begin
        for (int i = 0; i < IN_CHANNELS; i++) begin
            for (int dx = 0; dx < KERNEL_SIZE; dx++) begin
                for (int dy = 0; dy < KERNEL_SIZE; dy++) begin
                    weights_o[i][dx][dy] = weights_q[weight_index(int'(out_ch_i), i, dx, dy)];
                end
            end
        end
    end

    // Loader has to stay inside the bank
    weight_addr_range_a: assert property (
        @(posedge clock_i) disable iff (reset_i)
        weight_we_i |-> (int'(weight_addr_i) < WEIGHT_COUNT)
    ) else $error("weight write to address %0d outside the bank", weight_addr_i);

endmodule

/* design/kernel_mac.sv */
`timescale 1ns/1ns

module kernel_mac
    import layer_shape_pkg::*;
(
    window_if.mac win,
    input  weight_set_t weights_i,
    output pixel_t      result_o
);

    // Dot product of window and weight set
    always_comb begin
        product_t product;
        pixel_t   sum;

        sum = '0;
        for (int i = 0; i < IN_CHANNELS; i++) begin
            for (int dx = 0; dx < KERNEL_SIZE; dx++) begin
                for (int dy = 0; dy < KERNEL_SIZE; dy++) begin
                    // Full-width product, then back to the pixel's fixed-point scale
                    product = product_t'(weights_i[i][dx][dy]) * product_t'(win.taps[i][dx][dy]);
                    // Sum wraps modulo 2^VALUE_BITS
                    sum = sum + pixel_t'(product >> WEIGHT_Q_SHIFT);
                end
            end
        end
        result_o = sum;
    end

endmodule

/* design/layer_controller.sv */
`timescale 1ns/1ns

module layer_controller
    import layer_shape_pkg::*;
    import layer_ctrl_pkg::*;
(
    input  logic     clock_i,
    input  logic     reset_i,
    input  in_row_t  in_row_i,
    input  logic     in_row_valid_i,
    input  logic     in_row_last_i,
    input  tag_t     in_row_tag_i,
    output logic     in_row_accept_o,
    input  pixel_t   mac_result_i,
    output ch_idx_t  out_ch_o,
    window_if.ctrl   win,
    output out_row_t out_row_o,
    output logic     out_row_valid_o,
    output logic     out_row_last_o,
    output tag_t     out_row_tag_o,
    input  logic     out_row_accept_i
);

    ctrl_state_t state_q;
    ctrl_state_t next_state;
    row_fill_t   fill_q;
    col_idx_t    col_q;
    ch_idx_t     ch_q;
    logic        out_row_valid_q;
    logic        out_row_last_q;

    // Payload of the row that completed the window
    out_row_t out_row_q;
    tag_t     row_tag_q;
    logic     row_last_q;

    logic row_take;
    logic window_full;
    logic last_ch;
    logic last_col;

    assign row_take    = (state_q == GET_ROW) && in_row_valid_i;
    // One more row completes the window
    assign window_full = (fill_q >= row_fill_t'(KERNEL_SIZE - 1));
    assign last_ch     = (ch_q == ch_idx_t'(OUT_CHANNELS - 1));
    assign last_col    = (col_q == col_idx_t'(IMG_WIDTH - 1));

    assign in_row_accept_o = row_take;
    assign win.next_row    = in_row_i;
    assign win.shift_row   = row_take;
    assign win.shift_col   = (state_q == COMPUTE) && last_ch;
    assign out_ch_o        = ch_q;

    assign out_row_o       = out_row_q;
    assign out_row_valid_o = out_row_valid_q;
    assign out_row_last_o  = out_row_last_q;
    assign out_row_tag_o   = row_tag_q;

    always_comb begin
        next_state = state_q;
        case (state_q)
            GET_ROW: begin
                if (in_row_valid_i && window_full) begin
                    next_state = COMPUTE;
                end
            end
            COMPUTE: begin
                if (last_ch && last_col) begin
                    next_state = WAIT_READ;
                end
            end
            WAIT_READ: begin
                if (out_row_accept_i) begin
                    next_state = GET_ROW;
                end
            end
            default: next_state = GET_ROW;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q         <= GET_ROW;
            fill_q          <= '0;
            col_q           <= '0;
            ch_q            <= '0;
            out_row_valid_q <= 1'b0;
            out_row_last_q  <= 1'b0;
        end else begin
            state_q <= next_state;
            case (state_q)
                GET_ROW: begin
                    if (row_take) begin
                        if (window_full) begin
                            fill_q <= row_fill_t'(KERNEL_SIZE);
                            col_q  <= '0;
                            ch_q   <= '0;
                        end else if (in_row_last_i) begin
                            // Image too short for a window, start over
                            fill_q <= '0;
                        end else begin
                            fill_q <= fill_q + 1'b1;
                        end
                    end
                end
                COMPUTE: begin
                    if (last_ch) begin
                        ch_q  <= '0;
                        col_q <= col_q + 1'b1;
                    end else begin
                        ch_q <= ch_q + 1'b1;
                    end
                    if (last_ch && last_col) begin
                        out_row_valid_q <= 1'b1;
                        out_row_last_q  <= row_last_q;
                    end
                end
                WAIT_READ: begin
                    if (out_row_accept_i) begin
                        out_row_valid_q <= 1'b0;
                        out_row_last_q  <= 1'b0;
                        // Next image needs a full window again
                        if (row_last_q) begin
                            fill_q <= '0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (row_take) begin
            row_tag_q  <= in_row_tag_i;
            row_last_q <= in_row_last_i;
        end
        // Columns past the output width only rotate the buffer
        if ((state_q == COMPUTE) && (col_q < col_idx_t'(OUT_WIDTH))) begin
            out_row_q[col_q][ch_q] <= mac_result_i;
        end
    end

    // Finished row holds until the consumer takes it
    out_row_hold_a: assert property (
        @(posedge clock_i) disable iff (reset_i)
        (out_row_valid_o && !out_row_accept_i) |=>
            (out_row_valid_o && $stable(out_row_o) && $stable(out_row_tag_o)
             && $stable(out_row_last_o))
    ) else $error("output row dropped or changed before accept");

endmodule

/* design/conv_layer_top.sv */
`timescale 1ns/1ns

module conv_layer_top
    import layer_shape_pkg::*;
    import layer_ctrl_pkg::*;
(
    input  logic         clock_i,
    input  logic         reset_i,
    // Row input
    input  in_row_t      in_row_i,
    input  logic         in_row_valid_i,
    input  logic         in_row_last_i,
    input  tag_t         in_row_tag_i,
    output logic         in_row_accept_o,
    // Row output
    output out_row_t     out_row_o,
    output logic         out_row_valid_o,
    output logic         out_row_last_o,
    output tag_t         out_row_tag_o,
    input  logic         out_row_accept_i,
    // Weight load
    input  logic         weight_we_i,
    input  weight_addr_t weight_addr_i,
    input  weight_t      weight_data_i
);

    weight_set_t weights;
    pixel_t      mac_result;
    ch_idx_t     out_ch;

    window_if window_if_inst ();

    row_window_buffer row_window_buffer_inst (
        .clock_i (clock_i),
        .reset_i (reset_i),
        .win     (window_if_inst.buffer)
    );

    weight_bank weight_bank_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .weight_we_i   (weight_we_i),
        .weight_addr_i (weight_addr_i),
        .weight_data_i (weight_data_i),
        .out_ch_i      (out_ch),
        .weights_o     (weights)
    );

    kernel_mac kernel_mac_inst (
        .win       (window_if_inst.mac),
        .weights_i (weights),
        .result_o  (mac_result)
    );

    layer_controller layer_controller_inst (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_i         (in_row_i),
        .in_row_valid_i   (in_row_valid_i),
        .in_row_last_i    (in_row_last_i),
        .in_row_tag_i     (in_row_tag_i),
        .in_row_accept_o  (in_row_accept_o),
        .mac_result_i     (mac_result),
        .out_ch_o         (out_ch),
        .win              (window_if_inst.ctrl),
        .out_row_o        (out_row_o),
        .out_row_valid_o  (out_row_valid_o),
        .out_row_last_o   (out_row_last_o),
        .out_row_tag_o    (out_row_tag_o),
        .out_row_accept_i (out_row_accept_i)
    );

endmodule

/* tests/conv_layer_tb.sv */
`timescale 1ns/1ns

module conv_layer_tb
    import layer_shape_pkg::*;
();

    localparam int CLOCK_PERIOD  = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int IMAGE1_ROWS   = 6;
    localparam int IMAGE2_ROWS   = 5;
    localparam int TOTAL_ROWS    = IMAGE1_ROWS + IMAGE2_ROWS;
    localparam int WEIGHT_WRITES = 2 * WEIGHT_COUNT;
    localparam int TIMEOUT_CYCLES = TOTAL_ROWS * 40 + WEIGHT_WRITES + RESET_CYCLES + 200;
    // Valid is first seen at the edge after the last of the 16 compute cycles
    localparam int OUT_LATENCY   = IMG_WIDTH * OUT_CHANNELS + 1;

    logic         clock_i;
    logic         reset_i;
    in_row_t      in_row_i;
    logic         in_row_valid_i;
    logic         in_row_last_i;
    tag_t         in_row_tag_i;
    logic         in_row_accept_o;
    out_row_t     out_row_o;
    logic         out_row_valid_o;
    logic         out_row_last_o;
    tag_t         out_row_tag_o;
    logic         out_row_accept_i;
    logic         weight_we_i;
    weight_addr_t weight_addr_i;
    weight_t      weight_data_i;

    int seed = 47960;
    int accept_seed = 47960 + 1;
    int cycle_count = 0;
    int image_rows = 0;

    // Model state
    weight_t  ref_weights [WEIGHT_COUNT];
    in_row_t  hist [$];
    out_row_t exp_rows [$];
    tag_t     exp_tags [$];
    logic     exp_lasts [$];
    int       start_cycles [$];

    logic     prev_valid = 1'b0;
    logic     hold_pending = 1'b0;
    out_row_t held_row;
    tag_t     held_tag;
    logic     held_last;

    conv_layer_top conv_layer_top_inst (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_i         (in_row_i),
        .in_row_valid_i   (in_row_valid_i),
        .in_row_last_i    (in_row_last_i),
        .in_row_tag_i     (in_row_tag_i),
        .in_row_accept_o  (in_row_accept_o),
        .out_row_o        (out_row_o),
        .out_row_valid_o  (out_row_valid_o),
        .out_row_last_o   (out_row_last_o),
        .out_row_tag_o    (out_row_tag_o),
        .out_row_accept_i (out_row_accept_i),
        .weight_we_i      (weight_we_i),
        .weight_addr_i    (weight_addr_i),
        .weight_data_i    (weight_data_i)
    );

    initial begin
        clock_i = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock_i = ~clock_i;
        end
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_row(input string name, input out_row_t exp, input out_row_t act);
        for (int c = 0; c < OUT_WIDTH; c++) begin
            for (int o = 0; o < OUT_CHANNELS; o++) begin
                if (act[c][o] !== exp[c][o]) begin
                    $display("[FAIL] %0t %s[%0d][%0d] expected %0d actual %0d",
                             $time, name, c, o, exp[c][o], act[c][o]);
                    stop_run();
                end
            end
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // Flat address with dy varying fastest
    function automatic int weight_addr(int o, int i, int dx, int dy);
        return o * IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE + i * KERNEL_SIZE * KERNEL_SIZE
               + dx * KERNEL_SIZE + dy;
    endfunction

    // r0 is the oldest row of the window
    function automatic out_row_t ref_row(in_row_t r0, in_row_t r1, in_row_t r2);
        in_row_t  rows [KERNEL_SIZE];
        out_row_t result;
        int       sum;
        int       prod;

        rows[0] = r0;
        rows[1] = r1;
        rows[2] = r2;
        for (int c = 0; c < OUT_WIDTH; c++) begin
            for (int o = 0; o < OUT_CHANNELS; o++) begin
                sum = 0;
                for (int i = 0; i < IN_CHANNELS; i++) begin
                    for (int dx = 0; dx < KERNEL_SIZE; dx++) begin
                        for (int dy = 0; dy < KERNEL_SIZE; dy++) begin
                            prod = int'(ref_weights[weight_addr(o, i, dx, dy)])
                                 * int'(rows[dy][c + dx][i]);
                            sum = sum + (prod >> WEIGHT_Q_SHIFT);
                        end
                    end
                end
                result[c][o] = pixel_t'(sum % (1 << VALUE_BITS));
            end
        end
        return result;
    endfunction

    // Compare process samples on the rising edge before the DUT updates
    always @(posedge clock_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
        if (reset_i) begin
            prev_valid   = 1'b0;
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                check_flag("out_row_valid_o", 1'b1, out_row_valid_o);
                check_row("out_row_o", held_row, out_row_o);
                check_tag("out_row_tag_o", held_tag, out_row_tag_o);
                check_flag("out_row_last_o", held_last, out_row_last_o);
            end
            // Busy from window completion until the row is read
            if (exp_rows.size() > 0) begin
                check_flag("in_row_accept_o", 1'b0, in_row_accept_o);
            end
            if (out_row_valid_o && !prev_valid) begin
                if (start_cycles.size() == 0) begin
                    $display("Output row appeared at %0t without a completed window", $time);
                    stop_run();
                end
                check_latency("out_row_valid_o delay", OUT_LATENCY,
                              cycle_count - start_cycles.pop_front());
            end
            if (out_row_valid_o && out_row_accept_i) begin
                if (exp_rows.size() == 0) begin
                    $display("Output row read at %0t when none was expected", $time);
                    stop_run();
                end
                check_row("out_row_o", exp_rows.pop_front(), out_row_o);
                check_tag("out_row_tag_o", exp_tags.pop_front(), out_row_tag_o);
                check_flag("out_row_last_o", exp_lasts.pop_front(), out_row_last_o);
            end
            if (in_row_valid_i && in_row_accept_o) begin
                hist.push_back(in_row_i);
                if (hist.size() > KERNEL_SIZE) begin
                    void'(hist.pop_front());
                end
                image_rows++;
                if (image_rows >= KERNEL_SIZE) begin
                    exp_rows.push_back(ref_row(hist[0], hist[1], hist[2]));
                    exp_tags.push_back(in_row_tag_i);
                    exp_lasts.push_back(in_row_last_i);
                    start_cycles.push_back(cycle_count);
                end
                if (in_row_last_i) begin
                    image_rows = 0;
                    hist.delete();
                end
            end
            prev_valid   = out_row_valid_o;
            hold_pending = out_row_valid_o && !out_row_accept_i;
            held_row     = out_row_o;
            held_tag     = out_row_tag_o;
            held_last    = out_row_last_o;
        end
    end

    // Output back-pressure in random stretches
    initial begin
        logic level;
        int   len;

        out_row_accept_i = 1'b0;
        forever begin
            level = logic'($random(accept_seed) & 1);
            len   = 1 + ($random(accept_seed) & 7);
            repeat (len) begin
                @(posedge clock_i);
                #DRIVE_DELAY;
                out_row_accept_i = level;
            end
        end
    end

    task automatic step();
        @(posedge clock_i);
        #DRIVE_DELAY;
    endtask

    task automatic load_weights();
        for (int a = 0; a < WEIGHT_COUNT; a++) begin
            weight_we_i   = 1'b1;
            weight_addr_i = weight_addr_t'(a);
            weight_data_i = weight_t'($random(seed));
            ref_weights[a] = weight_data_i;
            step();
        end
        weight_we_i = 1'b0;
    endtask

    task automatic send_row(input tag_t tag, input logic last);
        for (int c = 0; c < IMG_WIDTH; c++) begin
            for (int ch = 0; ch < IN_CHANNELS; ch++) begin
                in_row_i[c][ch] = pixel_t'($random(seed));
            end
        end
        in_row_tag_i   = tag;
        in_row_last_i  = last;
        in_row_valid_i = 1'b1;
        @(posedge clock_i);
        while (!in_row_accept_o) begin
            @(posedge clock_i);
        end
        #DRIVE_DELAY;
        in_row_valid_i = 1'b0;
        in_row_last_i  = 1'b0;
    endtask

    // Partial window must not produce a row
    task automatic quiet_check();
        repeat (20) begin
            step();
        end
        @(posedge clock_i);
        check_flag("out_row_valid_o", 1'b0, out_row_valid_o);
        #DRIVE_DELAY;
    endtask

    task automatic send_image(input int rows, input int base_tag, input int pause_after);
        for (int r = 0; r < rows; r++) begin
            send_row(tag_t'(base_tag + r), r == rows - 1);
            if (r + 1 == pause_after) begin
                quiet_check();
            end
            repeat ($random(seed) & 1) begin
                step();
            end
        end
    endtask

    task automatic drain();
        while (exp_rows.size() > 0) begin
            step();
        end
    endtask

    initial begin
        reset_i        = 1'b1;
        in_row_i       = '0;
        in_row_valid_i = 1'b0;
        in_row_last_i  = 1'b0;
        in_row_tag_i   = '0;
        weight_we_i    = 1'b0;
        weight_addr_i  = '0;
        weight_data_i  = '0;
        for (int a = 0; a < WEIGHT_COUNT; a++) begin
            ref_weights[a] = '0;
        end
        repeat (RESET_CYCLES) begin
            @(posedge clock_i);
        end
        #DRIVE_DELAY;
        reset_i = 1'b0;
        @(posedge clock_i);
        check_flag("out_row_valid_o", 1'b0, out_row_valid_o);
        #DRIVE_DELAY;

        load_weights();
        send_image(IMAGE1_ROWS, 1, KERNEL_SIZE - 1);
        drain();

        // Second image on fresh weights
        load_weights();
        send_image(IMAGE2_ROWS, 8, KERNEL_SIZE - 1);
        drain();

        $display("Everything OK");
        $finish;
    end

endmodule

/* filelist.f */
design/layer_shape_pkg.sv
design/layer_ctrl_pkg.sv
design/window_if.sv
design/row_window_buffer.sv
design/weight_bank.sv
design/kernel_mac.sv
design/layer_controller.sv
design/conv_layer_top.sv
tests/conv_layer_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_layer_tb \
    -f filelist.f \
    -o conv_layer_sim

./obj_dir/conv_layer_sim
